// File: ramio_top.f
verilog/ramio_pkg.sv
verilog/br_pkg.sv
verilog/ramio_ifs.sv
verilog/ramio_req_decoder.sv
verilog/cache_bank.sv
verilog/br_arbiter.sv
verilog/ramio_top.sv
verif/br_ram_model.sv
verif/tb_ramio_top.sv

// File: verif/br_ram_model.sv
module br_ram_model (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         br_cmd,        // 0 read, 1 write
  input  logic                         br_cmd_en,
  input  logic [br_pkg::BR_ADDR_W-1:0] br_addr,
  input  logic [br_pkg::BR_DATA_W-1:0] br_wr_data,
  input  logic [br_pkg::BR_MASK_W-1:0] br_data_mask,
  output logic [br_pkg::BR_DATA_W-1:0] br_rd_data,
  output logic                         br_rd_data_valid
);

  localparam int NUM_LINES = 64;  // 512 byte window, 8 bytes per line

  logic [63:0] line_mem [NUM_LINES];
  logic        rd_pend = 1'b0;
  logic [5:0]  rd_idx  = '0;
  logic [3:0]  rd_wait = '0;
  logic [31:0] lcg_state = 32'd65;
  logic        valid_q = 1'b0;
  logic [63:0] data_q  = '0;

  assign br_rd_data_valid = valid_q;
  assign br_rd_data       = data_q;

  // own generator, picks 1 to 8 cycles of read delay
  function automatic logic [3:0] next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return 4'(((lcg_state >> 16) % 8) + 1);
  endfunction

  initial begin
    for (int i = 0; i < NUM_LINES; i++)
      line_mem[i] = '0;  // memory starts cleared
  end

  // --------------------------------------------------
  // command handling and delayed read return
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (br_cmd_en) begin
        if (br_cmd) begin
          for (int b = 0; b < 8; b++)
            if (!br_data_mask[b])  // mask bit set keeps old byte
              line_mem[br_addr[8:3]][8*b +: 8] <= br_wr_data[8*b +: 8];
        end else begin
          rd_pend <= 1'b1;
          rd_idx  <= br_addr[8:3];
          rd_wait <= next_delay();
        end
      end else if (rd_pend) begin
        if (rd_wait == 4'd1) begin
          valid_q <= 1'b1;           // single pulse
          data_q  <= line_mem[rd_idx];
          rd_pend <= 1'b0;
        end else begin
          rd_wait <= rd_wait - 4'd1;
        end
      end
    end
  end

endmodule

// File: verif/tb_ramio_top.sv
module tb_ramio_top;
  import ramio_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 400;
  localparam int N_OPS        = 4 + 2 + 17 + 256 + N_RANDOM; // all core accesses
  localparam int CYCLE_LIMIT  = N_OPS * 40 + RESET_CYCLES;   // evict + fill + hit path

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [1:0]  write_type;
  logic [2:0]  read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic        br_cmd;
  logic        br_cmd_en;
  logic [20:0] br_addr;
  logic [63:0] br_wr_data;
  logic [7:0]  br_data_mask;
  logic [63:0] br_rd_data;
  logic        br_rd_data_valid;

  logic [7:0]  mem_model [512];  // byte image of the window
  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          check_cnt;
  int          err_cnt;
  int          test_cnt;
  int          test_fail_cnt;
  int          test_err_start;
  int          rd_cmd_cnt;
  int          wb_cnt;
  logic        last_cmd;

  ramio_top dut_i (
    .clk, .rst_n, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy,
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  br_ram_model ram_i (
    .clk, .rst_n, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;  // low bits cycle too fast
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // expected load result straight from the byte image
  function automatic logic [31:0] predict_load(input logic [2:0] rt, input int a);
    logic [31:0] w;
    w = {mem_model[(a + 3) & 511], mem_model[(a + 2) & 511],
         mem_model[(a + 1) & 511], mem_model[a & 511]};
    case (rt)
      rt_byte:   return {{24{w[7]}}, w[7:0]};
      rt_half:   return {{16{w[15]}}, w[15:0]};
      rt_byte_u: return {24'd0, w[7:0]};
      rt_half_u: return {16'd0, w[15:0]};
      default:   return w;
    endcase
  endfunction

  // --------------------------------------------------
  // one core access, enable pulse then wait on busy
  // --------------------------------------------------
  task automatic run_op(input string name, input logic [1:0] wt, input logic [2:0] rt,
                        input int a, input logic [31:0] wdata);
    int nbytes;
    enable     <= 1'b1;
    write_type <= wt;
    read_type  <= rt;
    address    <= 32'(a);
    data_in    <= wdata;
    @(posedge clk);
    enable <= 1'b0;
    @(posedge clk);
    check({name, " busy after enable"}, 1, busy);
    while (busy) @(posedge clk);         // timeout monitor catches a hang
    if (wt != wt_none) begin
      check({name, " store ready"}, 0, data_out_ready);
      nbytes = (wt == wt_byte) ? 1 : (wt == wt_half) ? 2 : 4;
      for (int b = 0; b < nbytes; b++)
        mem_model[(a + b) & 511] = wdata[8*b +: 8];
    end else begin
      check({name, " load ready"}, 1, data_out_ready);
      check({name, " load data"}, predict_load(rt, a), data_out);
    end
  endtask

  task automatic start_test();
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt != test_err_start)
      test_fail_cnt++;
    $display("test %s done, %0d errors", name, err_cnt - test_err_start);
  endtask

  // --------------------------------------------------
  // burst port monitor, alignment and write-back data
  // --------------------------------------------------
  always @(posedge clk) begin : br_monitor
    logic [63:0] exp_line;
    int          base;
    if (rst_n && br_cmd_en) begin
      base = int'(br_addr);
      check("br_cmd line aligned", 0, br_addr[2:0]);
      check("br_cmd in window", 0, base >= 512);
      check("br_data_mask", 0, br_data_mask);
      last_cmd = br_cmd;
      if (br_cmd) begin
        wb_cnt++;
        for (int b = 0; b < 8; b++)
          exp_line[8*b +: 8] = mem_model[(base + b) & 511];
        check("write-back line", exp_line, br_wr_data);  // victim is current
      end else begin
        rd_cmd_cnt++;
      end
    end
  end

  always @(posedge clk) begin : hang_guard
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run hung, no completion after %0d cycles", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin : main
    int          rd_before;
    int          wb_before;
    int          a;
    logic [31:0] r;
    logic [1:0]  wt;
    logic [2:0]  rt;
    cycle_cnt     = 0;
    check_cnt     = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    rd_cmd_cnt    = 0;
    wb_cnt        = 0;
    last_cmd      = 1'b0;
    lcg_state     = 32'd65;
    rst_n         = 1'b0;
    enable        = 1'b0;
    write_type    = '0;
    read_type     = '0;
    address       = '0;
    data_in       = '0;
    for (int i = 0; i < 512; i++)
      mem_model[i] = 8'h00;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // reset state, cold loads read zero
    start_test();
    check("reset busy", 0, busy);
    check("reset data_out_ready", 0, data_out_ready);
    check("reset br_cmd_en", 0, br_cmd_en);
    run_op("reset load 000", wt_none, rt_word, 'h000, '0);
    run_op("reset load 044", wt_none, rt_word, 'h044, '0);
    run_op("reset load 108", wt_none, rt_word, 'h108, '0);
    run_op("reset load 1fc", wt_none, rt_word, 'h1fc, '0);
    end_test("reset");

    // fresh line, store fetches it first
    start_test();
    rd_before = rd_cmd_cnt;
    run_op("store_load st", wt_word, rt_none, 'h0a0, 32'hcafe_1234);
    check("store_load br_read count", rd_before + 1, rd_cmd_cnt);
    check("store_load br_cmd", 0, last_cmd);
    run_op("store_load ld", wt_none, rt_word, 'h0a0, '0);
    end_test("store_load");

    start_test();
    run_op("widths st word", wt_word, rt_none, 'h0c0, 32'h8081_7f80);
    for (int b = 0; b < 4; b++) begin
      run_op("widths ld byte", wt_none, rt_byte, 'h0c0 + b, '0);
      run_op("widths ld byte_u", wt_none, rt_byte_u, 'h0c0 + b, '0);
    end
    for (int h = 0; h < 4; h += 2) begin
      run_op("widths ld half", wt_none, rt_half, 'h0c0 + h, '0);
      run_op("widths ld half_u", wt_none, rt_half_u, 'h0c0 + h, '0);
    end
    run_op("widths st byte", wt_byte, rt_none, 'h0c1, 32'h0000_00f5);
    run_op("widths st half", wt_half, rt_none, 'h0c2, 32'h0000_9234);
    run_op("widths ld word", wt_none, rt_word, 'h0c0, '0);
    run_op("widths ld byte_u", wt_none, rt_byte_u, 'h0c1, '0);
    end_test("widths");

    // window is 4x the cache, so dirty lines get evicted
    start_test();
    wb_before = wb_cnt;
    for (int i = 0; i < 512; i += 4)
      run_op("eviction st", wt_word, rt_none, i, lcg_next() ^ (lcg_next() << 16));
    for (int i = 0; i < 512; i += 4)
      run_op("eviction ld", wt_none, rt_word, i, '0);
    check("eviction write-backs seen", 1, wb_cnt > wb_before);
    end_test("eviction");

    start_test();
    for (int n = 0; n < N_RANDOM; n++) begin
      r = lcg_next();
      a = int'(lcg_next() & 32'h1ff);
      if (r[4]) begin
        wt = 2'(1 + (r[9:5] % 3));
        a  = (wt == wt_word) ? (a & ~3) : (wt == wt_half) ? (a & ~1) : a;
        run_op("random st", wt, rt_none, a, lcg_next() ^ (lcg_next() << 16));
      end else begin
        rt = 3'(1 + (r[9:5] % 5));
        if (rt == rt_word)
          a = a & ~3;
        else if (rt == rt_half || rt == rt_half_u)
          a = a & ~1;
        run_op("random ld", wt_none, rt, a, '0);
      end
    end
    end_test("random_mix");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d write-backs",
             test_cnt, test_fail_cnt, check_cnt, err_cnt, wb_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verilog/br_arbiter.sv
module br_arbiter (
  input  logic                           clk,
  input  logic                           rst_n,
  br_port_if.arb                         ports [ramio_pkg::NUM_BANKS],
  output br_pkg::br_cmd_e                br_cmd,
  output logic                           br_cmd_en,
  output logic [br_pkg::BR_ADDR_W-1:0]   br_addr,
  output logic [br_pkg::BR_DATA_W-1:0]   br_wr_data,
  output logic [br_pkg::BR_MASK_W-1:0]   br_data_mask,
  input  logic [br_pkg::BR_DATA_W-1:0]   br_rd_data,
  input  logic                           br_rd_data_valid
);
  import ramio_pkg::*;
  import br_pkg::*;

  logic [NUM_BANKS-1:0]  req_v;
  br_cmd_e               cmd_v   [NUM_BANKS];
  logic [BR_ADDR_W-1:0]  addr_v  [NUM_BANKS];
  logic [BR_DATA_W-1:0]  wdata_v [NUM_BANKS];
  logic [NUM_BANKS-1:0]  grant_q;
  logic                  rd_pend_q;  // read waiting for its data
  logic [BANK_SEL_W-1:0] owner_q;    // bank that issued that read
  logic [BANK_SEL_W-1:0] last_q;     // round-robin pointer
  logic [BANK_SEL_W-1:0] pick;
  logic                  found;
  logic                  idle;

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_port
    assign req_v[g]         = ports[g].req;
    assign cmd_v[g]         = ports[g].cmd;
    assign addr_v[g]        = ports[g].line_addr;
    assign wdata_v[g]       = ports[g].wr_line;
    assign ports[g].grant   = grant_q[g];
    assign ports[g].rd_valid = br_rd_data_valid && rd_pend_q &&
                               (owner_q == BANK_SEL_W'(g));
    assign ports[g].rd_line = br_rd_data;
  end

  // grant cycle counts as busy, bank still shows its old req then
  assign idle = !rd_pend_q && !(|grant_q);

  // --------------------------------------------------
  // round-robin pick, starts after last winner
  // --------------------------------------------------
  always_comb begin
    logic [BANK_SEL_W-1:0] cand;
    found = 1'b0;
    pick  = last_q;
    for (int i = 1; i <= NUM_BANKS; i++) begin
      cand = BANK_SEL_W'((int'(last_q) + i) % NUM_BANKS);
      if (!found && req_v[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_q   <= '0;
      br_cmd_en <= 1'b0;
      rd_pend_q <= 1'b0;
      last_q    <= '0;
    end else begin
      grant_q   <= '0;
      br_cmd_en <= 1'b0;
      if (br_rd_data_valid) rd_pend_q <= 1'b0;    // read frees the port
      if (idle && found) begin
        grant_q[pick] <= 1'b1;
        br_cmd_en     <= 1'b1;
        last_q        <= pick;
        if (cmd_v[pick] == br_read) rd_pend_q <= 1'b1;
      end
    end
  end

  // command payload, qualified by br_cmd_en
  always_ff @(posedge clk) begin
    if (idle && found) begin
      br_cmd     <= cmd_v[pick];
      br_addr    <= addr_v[pick];
      br_wr_data <= wdata_v[pick];
      owner_q    <= pick;
    end
  end

  assign br_data_mask = '0;  // full line every time

  a_rd_expected: assert property (@(posedge clk) disable iff (!rst_n)
    br_rd_data_valid |-> rd_pend_q);

endmodule

// File: verilog/br_pkg.sv
package br_pkg;

  // burst RAM port geometry
  localparam int BR_ADDR_W  = 21;            // byte address
  localparam int BR_DATA_W  = 64;            // one cache line per burst
  localparam int BR_MASK_W  = BR_DATA_W / 8; // one bit per byte
  localparam int BR_ALIGN_W = $clog2(BR_MASK_W); // low addr bits of a line, always zero

  // command encoding as seen on br_cmd
  typedef enum logic {
    br_read  = 1'b0,
    br_write = 1'b1
  } br_cmd_e;

endpackage

// File: verilog/cache_bank.sv
module cache_bank (
  input  logic     clk,
  input  logic     rst_n,
  bank_req_if.bank req,
  br_port_if.bank  mem
);
  import ramio_pkg::*;
  import br_pkg::*;

  bank_state_e                state_q;
  logic [LINES_PER_BANK-1:0]  line_valid_q;
  logic [LINES_PER_BANK-1:0]  line_dirty_q;
  logic [TAG_W-1:0]           tag_q  [LINES_PER_BANK];
  logic [BR_DATA_W-1:0]       line_q [LINES_PER_BANK];

  // latched request
  write_type_e                wt_q;
  read_type_e                 rt_q;
  logic [ADDR_W-1:0]          addr_q;
  logic [DATA_W-1:0]          wdata_q;

  logic [INDEX_W-1:0]         idx;
  logic [TAG_W-1:0]           tag;
  logic [LINE_OFFS_W-1:0]     offs;
  logic                       hit;
  logic [BR_DATA_W-1:0]       cur_line;
  logic [BR_DATA_W-1:0]       shifted;
  logic [BR_MASK_W-1:0]       wmask;
  logic [BR_DATA_W-1:0]       wline;
  logic [BR_DATA_W-1:0]       merged;
  logic [DATA_W-1:0]          rdata_c;
  logic [ADDR_W-1:0]          evict_addr;
  logic [ADDR_W-1:0]          fill_addr;

  assign idx      = addr_q[INDEX_LSB +: INDEX_W];
  assign tag      = addr_q[TAG_LSB +: TAG_W];
  assign offs     = addr_q[LINE_OFFS_W-1:0];
  assign cur_line = line_q[idx];
  assign hit      = line_valid_q[idx] && (tag_q[idx] == tag);

  // --------------------------------------------------
  // FSM and line state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= st_idle;
      line_valid_q <= '0;
      line_dirty_q <= '0;
    end else begin
      case (state_q)
        st_idle:
          if (req.valid) state_q <= st_lookup;
        st_lookup: begin
          if (hit)
            state_q <= st_done;
          else if (line_valid_q[idx] && line_dirty_q[idx])
            state_q <= st_evict;                 // write back victim first
          else
            state_q <= st_fill;
        end
        st_evict:
          if (mem.grant) state_q <= st_fill;    // write is fire and forget
        st_fill:
          if (mem.grant) state_q <= st_wait_fill;
        st_wait_fill: begin
          if (mem.rd_valid) begin
            state_q           <= st_done;
            line_valid_q[idx] <= 1'b1;
            line_dirty_q[idx] <= 1'b0;          // fresh copy of memory
          end
        end
        st_done: begin
          state_q <= st_idle;
          if (wt_q != wt_none) line_dirty_q[idx] <= 1'b1;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // arrays and request payload
  always_ff @(posedge clk) begin
    if (state_q == st_idle && req.valid) begin
      wt_q    <= req.write_type;
      rt_q    <= req.read_type;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (state_q == st_wait_fill && mem.rd_valid) begin
      line_q[idx] <= mem.rd_line;
      tag_q[idx]  <= tag;
    end
    if (state_q == st_done && wt_q != wt_none)
      line_q[idx] <= merged;                    // store lands after fill or hit
  end

  // --------------------------------------------------
  // store merge, byte lanes of the line
  // --------------------------------------------------
  always_comb begin
    case (wt_q)
      wt_byte: begin
        wmask = BR_MASK_W'(8'h01) << offs;
        wline = {8{wdata_q[7:0]}};
      end
      wt_half: begin
        wmask = BR_MASK_W'(8'h03) << offs;
        wline = {4{wdata_q[15:0]}};
      end
      wt_word: begin
        wmask = BR_MASK_W'(8'h0f) << offs;
        wline = {2{wdata_q}};
      end
      default: begin
        wmask = '0;
        wline = '0;
      end
    endcase
    for (int b = 0; b < BR_MASK_W; b++)
      merged[8*b +: 8] = wmask[b] ? wline[8*b +: 8] : cur_line[8*b +: 8];
  end

  // load extract and extend
  always_comb begin
    shifted = cur_line >> {offs, 3'b000};
    case (rt_q)
      rt_byte:   rdata_c = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
      rt_half:   rdata_c = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
      rt_byte_u: rdata_c = {{(DATA_W-8){1'b0}}, shifted[7:0]};
      rt_half_u: rdata_c = {{(DATA_W-16){1'b0}}, shifted[15:0]};
      default:   rdata_c = shifted[DATA_W-1:0]; // word
    endcase
  end

  assign req.done  = (state_q == st_done);
  assign req.rdata = rdata_c;

  // --------------------------------------------------
  // line transfer request
  // --------------------------------------------------
  // victim lives in this bank, so bank bit comes from the current request
  assign evict_addr = {tag_q[idx], idx, addr_q[LINE_OFFS_W +: BANK_SEL_W],
                       {LINE_OFFS_W{1'b0}}};
  assign fill_addr  = {addr_q[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};

  assign mem.req       = (state_q == st_evict) || (state_q == st_fill);
  assign mem.cmd       = (state_q == st_evict) ? br_write : br_read;
  assign mem.line_addr = (state_q == st_evict) ? evict_addr[BR_ADDR_W-1:0]
                                               : fill_addr[BR_ADDR_W-1:0];
  assign mem.wr_line   = cur_line;

  // request level must survive until the arbiter has taken it
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(mem.req) |-> $past(mem.grant));

endmodule

// File: verilog/ramio_ifs.sv
// --------------------------------------------------
// decoder to bank request path
// --------------------------------------------------
interface bank_req_if;
  import ramio_pkg::*;

  logic                valid;      // one cycle strobe
  write_type_e         write_type;
  read_type_e          read_type;
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic                done;       // one cycle pulse from bank
  logic [DATA_W-1:0]   rdata;      // already extended

  modport dec  (output valid, write_type, read_type, addr, wdata, input done, rdata);
  modport bank (input valid, write_type, read_type, addr, wdata, output done, rdata);
endinterface

// --------------------------------------------------
// bank to arbiter line transfer path
// --------------------------------------------------
interface br_port_if;
  import br_pkg::*;

  logic                 req;       // level, held until grant
  br_cmd_e              cmd;
  logic [BR_ADDR_W-1:0] line_addr;
  logic [BR_DATA_W-1:0] wr_line;
  logic                 grant;     // pulse when cmd hits the burst port
  logic                 rd_valid;  // fill data returned
  logic [BR_DATA_W-1:0] rd_line;

  modport bank (output req, cmd, line_addr, wr_line, input grant, rd_valid, rd_line);
  modport arb  (input req, cmd, line_addr, wr_line, output grant, rd_valid, rd_line);
endinterface

// File: verilog/ramio_pkg.sv
package ramio_pkg;

  // --------------------------------------------------
  // core side access codes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    wt_none = 2'd0, // no store
    wt_byte = 2'd1,
    wt_half = 2'd2,
    wt_word = 2'd3
  } write_type_e;

  // plain byte/half sign-extend, _u variants zero-extend
  typedef enum logic [2:0] {
    rt_none   = 3'd0,
    rt_byte   = 3'd1,
    rt_half   = 3'd2,
    rt_word   = 3'd3,
    rt_byte_u = 3'd4,
    rt_half_u = 3'd5
  } read_type_e;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // --------------------------------------------------
  // address split and cache geometry
  // --------------------------------------------------
  localparam int NUM_BANKS      = 2;
  localparam int BANK_SEL_W     = $clog2(NUM_BANKS); // address bit 3
  localparam int LINE_OFFS_W    = 3;                 // 8-byte line
  localparam int LINES_PER_BANK = 8;
  localparam int INDEX_W        = $clog2(LINES_PER_BANK);
  localparam int INDEX_LSB      = LINE_OFFS_W + BANK_SEL_W; // bits 6:4
  localparam int TAG_LSB        = INDEX_LSB + INDEX_W;
  localparam int TAG_W          = ADDR_W - TAG_LSB;

  typedef enum logic [2:0] {
    st_idle, st_lookup, st_evict, st_fill, st_wait_fill, st_done
  } bank_state_e;

endpackage

// File: verilog/ramio_req_decoder.sv
module ramio_req_decoder (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           enable,
  input  ramio_pkg::write_type_e         write_type,
  input  ramio_pkg::read_type_e          read_type,
  input  logic [ramio_pkg::ADDR_W-1:0]   address,
  input  logic [ramio_pkg::DATA_W-1:0]   data_in,
  output logic [ramio_pkg::DATA_W-1:0]   data_out,
  output logic                           data_out_ready,
  output logic                           busy,
  bank_req_if.dec                        banks [ramio_pkg::NUM_BANKS]
);
  import ramio_pkg::*;

  logic                  valid_q;   // strobe toward selected bank
  logic                  busy_q;
  logic                  accept;
  logic [BANK_SEL_W-1:0] sel_q;
  logic                  is_load_q;
  write_type_e           wt_q;
  read_type_e            rt_q;
  logic [ADDR_W-1:0]     addr_q;
  logic [DATA_W-1:0]     wdata_q;
  logic [NUM_BANKS-1:0]  done_v;
  logic [DATA_W-1:0]     rdata_v [NUM_BANKS];
  logic                  done_sel;
  logic                  misaligned;

  assign accept = enable && !busy;

  // --------------------------------------------------
  // request capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      valid_q <= accept;                // single cycle strobe
      if (accept)
        busy_q <= 1'b1;
      else if (done_sel)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q     <= address[LINE_OFFS_W +: BANK_SEL_W]; // bit 3 picks the bank
      is_load_q <= (read_type != rt_none);
      wt_q      <= write_type;
      rt_q      <= read_type;
      addr_q    <= address;
      wdata_q   <= data_in;
    end
  end

  // fan out to banks, gather done and rdata back
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_route
    assign banks[g].valid      = valid_q && (sel_q == BANK_SEL_W'(g));
    assign banks[g].write_type = wt_q;
    assign banks[g].read_type  = rt_q;
    assign banks[g].addr       = addr_q;
    assign banks[g].wdata      = wdata_q;
    assign done_v[g]           = banks[g].done;
    assign rdata_v[g]          = banks[g].rdata;
  end

  // --------------------------------------------------
  // core side return, same cycle as bank done
  // --------------------------------------------------
  assign done_sel       = done_v[sel_q];
  assign busy           = busy_q && !done_sel;       // drops in completion cycle
  assign data_out_ready = busy_q && done_sel && is_load_q; // stores finish silently
  assign data_out       = rdata_v[sel_q];

  // alignment by access width
  always_comb begin
    misaligned = 1'b0;
    if (write_type == wt_word || read_type == rt_word)
      misaligned = |address[1:0];
    else if (write_type == wt_half || read_type inside {rt_half, rt_half_u})
      misaligned = address[0];
  end

  a_no_enable_busy: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> !busy);

  // a misaligned access would straddle banks or lines
  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> !misaligned);

endmodule

// File: verilog/ramio_top.sv
module ramio_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // core side
  input  logic                          enable,
  input  logic [1:0]                    write_type,
  input  logic [2:0]                    read_type,
  input  logic [ramio_pkg::ADDR_W-1:0]  address,
  input  logic [ramio_pkg::DATA_W-1:0]  data_in,
  output logic [ramio_pkg::DATA_W-1:0]  data_out,
  output logic                          data_out_ready,
  output logic                          busy,
  // burst RAM side
  output logic                          br_cmd,       // 0 read, 1 write
  output logic                          br_cmd_en,
  output logic [br_pkg::BR_ADDR_W-1:0]  br_addr,
  output logic [br_pkg::BR_DATA_W-1:0]  br_wr_data,
  output logic [br_pkg::BR_MASK_W-1:0]  br_data_mask,
  input  logic [br_pkg::BR_DATA_W-1:0]  br_rd_data,
  input  logic                          br_rd_data_valid
);
  import ramio_pkg::*;

  write_type_e wt;
  read_type_e  rt;

  assign wt = write_type_e'(write_type);
  assign rt = read_type_e'(read_type);

  bank_req_if bank_if [NUM_BANKS] ();
  br_port_if  br_if   [NUM_BANKS] ();

  // --------------------------------------------------
  // decoder, banks, arbiter
  // --------------------------------------------------
  ramio_req_decoder dec_i (
    .clk, .rst_n, .enable,
    .write_type (wt),
    .read_type  (rt),
    .address, .data_in, .data_out, .data_out_ready, .busy,
    .banks      (bank_if)
  );

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    cache_bank bank_i (.clk, .rst_n, .req(bank_if[g]), .mem(br_if[g]));
  end

  br_arbiter arb_i (
    .clk, .rst_n,
    .ports (br_if),
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid
  );

endmodule
